// File: verilog/rv_pkg.sv
// RV32I instruction-set types, opcodes, ALU operations and instruction classes
// Imported by the decode, execute and register units of the core
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_BRANCH,
        CLS_JUMP,
        CLS_LOAD,
        CLS_STORE,
        CLS_HALT,
        CLS_ILLEGAL
    } inst_class_t;

    localparam word_t      EBREAK_WORD = 32'h0010_0073;
    localparam logic [2:0] F3_WORD     = 3'b010;  // Only LW and SW supported

endpackage

`default_nettype wire

// File: verilog/mem_pkg.sv
// Shared memory map and requester identities for the unified word memory
`default_nettype none

package mem_pkg;

    localparam int          MEM_WORDS = 1024;
    localparam logic [31:0] RESET_PC  = 32'h0000_0000;

    typedef logic [9:0] mem_addr_t;  // Word address

    // Listed in arbitration priority order
    typedef enum logic [1:0] {
        REQ_HOST,
        REQ_LSU,
        REQ_FETCH
    } req_id_t;

endpackage

`default_nettype wire

// File: verilog/regfile.sv
// 32 x 32 general register file, two asynchronous reads and one write port
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic              clk,
    input  logic              reset,
    input  logic              we,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2
);
    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // Execute unit never enables write-back for rd = x0
    a_no_x0_write: assert property (@(posedge clk) disable iff (reset) we |-> waddr != '0);

endmodule

`default_nettype wire

// File: verilog/unified_mem.sv
// Single-port word memory shared by code and data, ack one cycle after req
`timescale 1ns/1ps
`default_nettype none

module unified_mem (
    input  logic               clk,
    input  logic               reset,
    input  logic               req,
    input  logic               we,
    input  mem_pkg::mem_addr_t addr,
    input  rv_pkg::word_t      wdata,
    output logic               ack,
    output rv_pkg::word_t      rdata
);
    import rv_pkg::*;
    import mem_pkg::*;

    word_t mem [MEM_WORDS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) ack <= 1'b0;
        else ack <= req;
    end

    always_ff @(posedge clk) begin
        if (req) begin
            if (we) mem[addr] <= wdata;
            rdata <= mem[addr];  // Old word on a write
        end
    end

    // Arbiter drops req while the ack is out
    a_no_req_in_ack: assert property (@(posedge clk) disable iff (reset) ack |-> !req);

endmodule

`default_nettype wire

// File: verilog/mem_arbiter.sv
// Fixed-priority arbiter for host, LSU and fetch onto the unified memory
// Grant is held from request until the memory ack
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic               clk,
    input  logic               reset,
    input  logic               host_req,
    input  logic               host_we,
    input  mem_pkg::mem_addr_t host_addr,
    input  rv_pkg::word_t      host_wdata,
    output logic               host_ack,
    output rv_pkg::word_t      host_rdata,
    input  logic               lsu_req,
    input  logic               lsu_we,
    input  mem_pkg::mem_addr_t lsu_addr,
    input  rv_pkg::word_t      lsu_wdata,
    output logic               lsu_ack,
    output rv_pkg::word_t      lsu_rdata,
    input  logic               fetch_req,
    input  mem_pkg::mem_addr_t fetch_addr,
    output logic               fetch_ack,
    output rv_pkg::word_t      fetch_rdata,
    output logic               mem_req,
    output logic               mem_we,
    output mem_pkg::mem_addr_t mem_addr,
    output rv_pkg::word_t      mem_wdata,
    input  logic               mem_ack,
    input  rv_pkg::word_t      mem_rdata
);
    import mem_pkg::*;

    logic    busy;
    req_id_t owner;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy  <= 1'b0;
            owner <= REQ_HOST;
        end else if (!busy) begin
            busy <= host_req || lsu_req || fetch_req;
            if (host_req) owner <= REQ_HOST;
            else if (lsu_req) owner <= REQ_LSU;
            else if (fetch_req) owner <= REQ_FETCH;
        end else if (mem_ack) begin
            busy <= 1'b0;
        end
    end

    assign mem_req = busy && !mem_ack;  // One access per grant

    always_comb begin
        case (owner)
            REQ_HOST: begin
                mem_we    = host_we;
                mem_addr  = host_addr;
                mem_wdata = host_wdata;
            end
            REQ_LSU: begin
                mem_we    = lsu_we;
                mem_addr  = lsu_addr;
                mem_wdata = lsu_wdata;
            end
            default: begin
                mem_we    = 1'b0;
                mem_addr  = fetch_addr;
                mem_wdata = '0;
            end
        endcase
    end

    assign host_ack    = mem_ack && owner == REQ_HOST;
    assign lsu_ack     = mem_ack && owner == REQ_LSU;
    assign fetch_ack   = mem_ack && owner == REQ_FETCH;
    assign host_rdata  = mem_rdata;
    assign lsu_rdata   = mem_rdata;
    assign fetch_rdata = mem_rdata;

    // Each memory ack reaches exactly one requester still waiting for it
    a_ack_onehot: assert property (@(posedge clk) disable iff (reset)
        mem_ack |-> $onehot({host_ack && host_req, lsu_ack && lsu_req,
                             fetch_ack && fetch_req}));

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
// PC and instruction register with the fetch FSM of the multi-cycle core
// Also holds the sticky halted and error status
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                run,
    input  logic                done,
    input  rv_pkg::inst_class_t inst_class,
    input  rv_pkg::word_t       next_pc,
    output logic                mem_req,
    output mem_pkg::mem_addr_t  mem_addr,
    input  logic                mem_ack,
    input  rv_pkg::word_t       mem_rdata,
    output rv_pkg::word_t       pc,
    output rv_pkg::word_t       inst,
    output logic                inst_valid,
    output logic                halted,
    output logic                error
);
    import rv_pkg::*;
    import mem_pkg::*;

    typedef enum logic [1:0] {FETCH, WAIT_ACK, EXEC, STOP} state_t;

    state_t state;

    assign mem_req  = (state == FETCH && run) || state == WAIT_ACK;
    assign mem_addr = pc[$bits(mem_addr_t)+1:2];  // Byte PC to word address

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= FETCH;
            pc         <= RESET_PC;
            inst_valid <= 1'b0;
            halted     <= 1'b0;
            error      <= 1'b0;
        end else begin
            inst_valid <= 1'b0;
            case (state)
                FETCH: if (run) state <= WAIT_ACK;
                WAIT_ACK: begin
                    if (mem_ack) begin
                        state      <= EXEC;
                        inst_valid <= 1'b1;
                    end
                end
                EXEC: begin
                    if (done) begin
                        pc <= next_pc;
                        if (inst_class == CLS_HALT) begin
                            halted <= 1'b1;
                            state  <= STOP;
                        end else if (inst_class == CLS_ILLEGAL) begin
                            error <= 1'b1;
                            state <= STOP;
                        end else begin
                            state <= FETCH;
                        end
                    end
                end
                default: ;  // Stays stopped until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WAIT_ACK && mem_ack) inst <= mem_rdata;
    end

    // One instruction in flight, so no fetch overlaps its start
    a_no_fetch_on_issue: assert property (@(posedge clk) disable iff (reset)
        inst_valid |-> !mem_req && !mem_ack);

endmodule

`default_nettype wire

// File: verilog/decoder.sv
// RV32I decoder for fields, immediates, ALU operation and instruction class
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  rv_pkg::word_t       inst,
    output rv_pkg::reg_addr_t   rs1,
    output rv_pkg::reg_addr_t   rs2,
    output rv_pkg::reg_addr_t   rd,
    output rv_pkg::word_t       imm,
    output rv_pkg::alu_op_t     alu_op,
    output rv_pkg::inst_class_t inst_class,
    output logic [2:0]          funct3,
    output logic                use_imm,
    output logic                pc_base,
    output logic                zero_base
);
    import rv_pkg::*;

    word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_t arith_op;

    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (inst[5] && inst[30]) ? ALU_SUB : ALU_ADD;  // SUB is reg form only
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = inst[30] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        imm        = imm_i;
        alu_op     = ALU_ADD;
        inst_class = CLS_ILLEGAL;
        use_imm    = 1'b1;
        pc_base    = 1'b0;
        zero_base  = 1'b0;
        case (inst[6:0])
            OPC_LUI: begin
                imm        = imm_u;
                zero_base  = 1'b1;
                inst_class = CLS_ALU;
            end
            OPC_AUIPC: begin
                imm        = imm_u;
                pc_base    = 1'b1;
                inst_class = CLS_ALU;
            end
            OPC_JAL: begin
                imm        = imm_j;
                pc_base    = 1'b1;
                inst_class = CLS_JUMP;
            end
            OPC_JALR: inst_class = (funct3 == 3'b000) ? CLS_JUMP : CLS_ILLEGAL;
            OPC_BRANCH: begin
                imm        = imm_b;
                pc_base    = 1'b1;  // ALU forms the target
                inst_class = (funct3[2:1] == 2'b01) ? CLS_ILLEGAL : CLS_BRANCH;
            end
            OPC_LOAD: inst_class = (funct3 == F3_WORD) ? CLS_LOAD : CLS_ILLEGAL;
            OPC_STORE: begin
                imm        = imm_s;
                inst_class = (funct3 == F3_WORD) ? CLS_STORE : CLS_ILLEGAL;
            end
            OPC_OP_IMM: begin
                alu_op     = arith_op;
                inst_class = CLS_ALU;
            end
            OPC_OP: begin
                alu_op     = arith_op;
                use_imm    = 1'b0;
                inst_class = CLS_ALU;
            end
            OPC_SYSTEM: inst_class = (inst == EBREAK_WORD) ? CLS_HALT : CLS_ILLEGAL;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/execute_unit.sv
// ALU, branch compare, next-PC and write-back selection for the current instruction
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  rv_pkg::inst_class_t inst_class,
    input  rv_pkg::alu_op_t     alu_op,
    input  logic [2:0]          funct3,
    input  rv_pkg::word_t       imm,
    input  logic                use_imm,
    input  logic                pc_base,
    input  logic                zero_base,
    input  rv_pkg::word_t       pc,
    input  rv_pkg::word_t       rs1_data,
    input  rv_pkg::word_t       rs2_data,
    input  rv_pkg::word_t       load_data,
    input  rv_pkg::reg_addr_t   rd,
    output mem_pkg::mem_addr_t  mem_addr,
    output rv_pkg::word_t       store_data,
    output rv_pkg::word_t       next_pc,
    output logic                wb_en,
    output rv_pkg::word_t       wb_data
);
    import rv_pkg::*;
    import mem_pkg::*;

    word_t op_a, op_b, alu_result, pc_plus4;
    logic  taken;

    assign op_a     = zero_base ? '0 : (pc_base ? pc : rs1_data);
    assign op_b     = use_imm ? imm : rs2_data;
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (alu_op)
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << op_b[4:0];
            ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {31'b0, op_a < op_b};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> op_b[4:0];
            ALU_SRA:  alu_result = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            default:  alu_result = op_a + op_b;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  taken = rs1_data == rs2_data;
            3'b001:  taken = rs1_data != rs2_data;
            3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);
            3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);
            3'b110:  taken = rs1_data < rs2_data;
            3'b111:  taken = rs1_data >= rs2_data;
            default: taken = 1'b0;
        endcase
    end

    assign mem_addr   = alu_result[$bits(mem_addr_t)+1:2];
    assign store_data = rs2_data;

    always_comb begin
        if (inst_class == CLS_JUMP) begin
            next_pc = {alu_result[31:1], 1'b0};  // JALR drops bit 0
        end else if (inst_class == CLS_BRANCH && taken) begin
            next_pc = alu_result;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_comb begin
        case (inst_class)
            CLS_JUMP: wb_data = pc_plus4;
            CLS_LOAD: wb_data = load_data;
            default:  wb_data = alu_result;
        endcase
    end

    assign wb_en = (inst_class == CLS_ALU || inst_class == CLS_JUMP || inst_class == CLS_LOAD)
                   && rd != '0;

endmodule

`default_nettype wire

// File: verilog/load_store_unit.sv
// Issues word loads and stores and ends every instruction with one done pulse
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                inst_valid,
    input  rv_pkg::inst_class_t inst_class,
    input  mem_pkg::mem_addr_t  addr,
    input  rv_pkg::word_t       store_data,
    output logic                mem_req,
    output logic                mem_we,
    output mem_pkg::mem_addr_t  mem_addr,
    output rv_pkg::word_t       mem_wdata,
    input  logic                mem_ack,
    input  rv_pkg::word_t       mem_rdata,
    output rv_pkg::word_t       load_data,
    output logic                done
);
    import rv_pkg::*;

    logic is_mem;

    assign is_mem    = inst_class == CLS_LOAD || inst_class == CLS_STORE;
    assign mem_we    = inst_class == CLS_STORE;
    assign mem_addr  = addr;  // Stable until done
    assign mem_wdata = store_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_req <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= (inst_valid && !is_mem) || (mem_req && mem_ack);
            if (inst_valid && is_mem) begin
                mem_req <= 1'b1;
            end else if (mem_ack) begin
                mem_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req && mem_ack && !mem_we) load_data <= mem_rdata;
    end

endmodule

`default_nettype wire

// File: verilog/core_top.sv
// Multi-cycle RV32I core with a host loader port on one shared word memory
// Retire strobe reports PC, destination register and write-back data
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               run,
    input  logic               host_req,
    input  logic               host_we,
    input  mem_pkg::mem_addr_t host_addr,
    input  rv_pkg::word_t      host_wdata,
    output logic               host_ack,
    output rv_pkg::word_t      host_rdata,
    output logic               retire_valid,
    output rv_pkg::word_t      retire_pc,
    output rv_pkg::reg_addr_t  retire_rd,
    output rv_pkg::word_t      retire_wdata,
    output logic               halted,
    output logic               error
);
    import rv_pkg::*;
    import mem_pkg::*;

    word_t       pc, inst, next_pc, imm, rs1_data, rs2_data;
    word_t       load_data, store_data, wb_data;
    reg_addr_t   rs1, rs2, rd;
    alu_op_t     alu_op;
    inst_class_t inst_class;
    logic [2:0]  funct3;
    logic        inst_valid, use_imm, pc_base, zero_base, wb_en, done;
    mem_addr_t   ls_addr;

    logic      fetch_req, fetch_ack;
    mem_addr_t fetch_addr;
    word_t     fetch_rdata;
    logic      lsu_req, lsu_we, lsu_ack;
    mem_addr_t lsu_addr;
    word_t     lsu_wdata, lsu_rdata;
    logic      mem_req, mem_we, mem_ack;
    mem_addr_t mem_addr;
    word_t     mem_wdata, mem_rdata;

    assign retire_valid = done;
    assign retire_pc    = pc;
    assign retire_rd    = wb_en ? rd : '0;
    assign retire_wdata = wb_data;

    fetch_unit u_fetch (
        .clk(clk), .reset(reset), .run(run), .done(done),
        .inst_class(inst_class), .next_pc(next_pc),
        .mem_req(fetch_req), .mem_addr(fetch_addr), .mem_ack(fetch_ack),
        .mem_rdata(fetch_rdata), .pc(pc), .inst(inst), .inst_valid(inst_valid),
        .halted(halted), .error(error)
    );

    decoder u_decoder (
        .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
        .inst_class(inst_class), .funct3(funct3), .use_imm(use_imm),
        .pc_base(pc_base), .zero_base(zero_base)
    );

    execute_unit u_execute (
        .inst_class(inst_class), .alu_op(alu_op), .funct3(funct3), .imm(imm),
        .use_imm(use_imm), .pc_base(pc_base), .zero_base(zero_base), .pc(pc),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .load_data(load_data), .rd(rd),
        .mem_addr(ls_addr), .store_data(store_data), .next_pc(next_pc),
        .wb_en(wb_en), .wb_data(wb_data)
    );

    regfile u_regfile (
        .clk(clk), .reset(reset), .we(done && wb_en), .waddr(rd), .wdata(wb_data),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data)
    );

    load_store_unit u_lsu (
        .clk(clk), .reset(reset), .inst_valid(inst_valid), .inst_class(inst_class),
        .addr(ls_addr), .store_data(store_data), .mem_req(lsu_req), .mem_we(lsu_we),
        .mem_addr(lsu_addr), .mem_wdata(lsu_wdata), .mem_ack(lsu_ack),
        .mem_rdata(lsu_rdata), .load_data(load_data), .done(done)
    );

    mem_arbiter u_arbiter (
        .clk(clk), .reset(reset),
        .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_ack(host_ack), .host_rdata(host_rdata),
        .lsu_req(lsu_req), .lsu_we(lsu_we), .lsu_addr(lsu_addr),
        .lsu_wdata(lsu_wdata), .lsu_ack(lsu_ack), .lsu_rdata(lsu_rdata),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_ack(fetch_ack),
        .fetch_rdata(fetch_rdata),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    unified_mem u_mem (
        .clk(clk), .reset(reset), .req(mem_req), .we(mem_we), .addr(mem_addr),
        .wdata(mem_wdata), .ack(mem_ack), .rdata(mem_rdata)
    );

endmodule

`default_nettype wire

// File: testbench/tb_core_top.sv
// Testbench for the multi-cycle RV32I core, driven by records from the pattern file
// Loads programs through the host port and checks retire records, flags and memory words
`timescale 1ns/1ps
`default_nettype none

module tb_core_top;
    import rv_pkg::*;
    import mem_pkg::*;

    localparam int WAIT_LIMIT   = 2000;
    localparam int QUIET_CYCLES = 20;
    localparam int RANDOM_WORDS = 16;
    localparam     PATTERN_FILE = "testbench/core_patterns.txt";

    logic      clk;
    logic      reset;
    logic      run;
    logic      host_req;
    logic      host_we;
    mem_addr_t host_addr;
    word_t     host_wdata;
    logic      host_ack;
    word_t     host_rdata;
    logic      retire_valid;
    word_t     retire_pc;
    reg_addr_t retire_rd;
    word_t     retire_wdata;
    logic      halted;
    logic      error;

    int     errors = 0;
    int     test_errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    logic   aborted = 1'b0;
    string  test_name = "";
    integer seed;
    word_t  shadow [MEM_WORDS];  // Last word written per address

    core_top dut (
        .clk(clk), .reset(reset), .run(run),
        .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_ack(host_ack), .host_rdata(host_rdata),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_wdata(retire_wdata), .halted(halted), .error(error)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in test %s: no %s within %0d cycles", test_name, what, WAIT_LIMIT);
        note_error();
        aborted = 1'b1;
    endtask

    task automatic check_word(input string what, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
            note_error();
        end
    endtask

    task automatic check_reg(input string what, input reg_addr_t expected,
                             input reg_addr_t actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected x%0d, actual x%0d", test_name, what, expected, actual);
            note_error();
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %b, actual %b", test_name, what, expected, actual);
            note_error();
        end
    endtask

    task automatic finish_test();
        if (test_name != "") begin
            tests_run++;
            if (test_errors == 0) begin
                $display("Test %s: ok", test_name);
            end else begin
                $display("Test %s: %0d error(s)", test_name, test_errors);
                tests_failed++;
            end
        end
    endtask

    task automatic start_test(input string name);
        finish_test();
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic drive_step();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        drive_step();
        reset    = 1'b1;
        run      = 1'b0;
        host_req = 1'b0;
        repeat (4) @(posedge clk);
        #2 reset = 1'b0;
    endtask

    // Request held until the ack pulse, then dropped after the next edge
    task automatic host_access(input logic we, input mem_addr_t addr, input word_t wdata,
                               output word_t rdata);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        rdata  = '0;
        drive_step();
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            seen = host_ack;
            cycles++;
        end
        if (!seen) report_timeout($sformatf("host ack for address %h", addr));
        else rdata = host_rdata;
        drive_step();
        host_req = 1'b0;
        host_we  = 1'b0;
    endtask

    task automatic host_random_test();
        mem_addr_t addrs [RANDOM_WORDS];
        word_t     value;
        word_t     rdata;
        start_test("host_rw");
        seed = 32'h9939_208e;
        for (int i = 0; i < RANDOM_WORDS; i++) begin
            addrs[i] = mem_addr_t'($random(seed));
            value    = $random(seed);
            shadow[addrs[i]] = value;
            host_access(1'b1, addrs[i], value, rdata);
        end
        shadow[addrs[0]] = ~shadow[addrs[0]];  // Second write to the same word
        host_access(1'b1, addrs[0], shadow[addrs[0]], rdata);
        for (int i = 0; i < RANDOM_WORDS; i++) begin
            host_access(1'b0, addrs[i], '0, rdata);
            check_word($sformatf("mem[%h]", addrs[i]), shadow[addrs[i]], rdata);
        end
    endtask

    task automatic wait_retire(input word_t exp_pc, input reg_addr_t exp_rd,
                               input word_t exp_data);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            seen = retire_valid;
            cycles++;
        end
        if (!seen) begin
            report_timeout($sformatf("retire of pc %h", exp_pc));
        end else begin
            check_word($sformatf("pc %h", exp_pc), exp_pc, retire_pc);
            check_reg($sformatf("rd at pc %h", exp_pc), exp_rd, retire_rd);
            if (exp_rd != '0) begin
                check_word($sformatf("data at pc %h", exp_pc), exp_data, retire_wdata);
            end
        end
    endtask

    task automatic wait_stop(input logic want_halt);
        int   cycles;
        int   extra;
        logic seen;
        cycles = 0;
        extra  = 0;
        seen   = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            seen = want_halt ? halted : error;
            cycles++;
        end
        if (!seen) begin
            report_timeout(want_halt ? "halted level" : "error level");
        end else begin
            check_flag(want_halt ? "error" : "halted", 1'b0, want_halt ? error : halted);
            repeat (QUIET_CYCLES) begin
                @(negedge clk);
                if (retire_valid) extra++;
            end
            if (extra != 0) begin
                $display("Test %s: retire_valid pulsed %0d time(s) after the core stopped",
                         test_name, extra);
                note_error();
            end
        end
    endtask

    task automatic bad_record(input string kind);
        $display("Error: malformed or unknown %s record in the pattern file", kind);
        note_error();
        aborted = 1'b1;
    endtask

    initial begin
        integer            fd;
        integer            code;
        logic [8*16-1:0]   cmd;
        logic [8*16-1:0]   label;
        logic [8*128-1:0]  line;
        mem_addr_t         addr;
        word_t             value;
        word_t             pc_val;
        word_t             rdata;
        reg_addr_t         rd_val;

        reset      = 1'b1;
        run        = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        apply_reset();
        host_random_test();

        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Error: pattern file %s could not be opened", PATTERN_FILE);
            note_error();
        end else begin
            while (!aborted && $fscanf(fd, "%s", cmd) == 1) begin
                case (cmd)
                    "#": code = $fgets(line, fd);  // Comment line
                    "test": begin
                        code = $fscanf(fd, "%s", label);
                        start_test(string'(label));
                    end
                    "load": begin
                        code = $fscanf(fd, "%h %h", addr, value);
                        if (code != 2) bad_record("load");
                        else host_access(1'b1, addr, value, rdata);
                    end
                    "run": begin
                        drive_step();
                        run = 1'b1;
                    end
                    "retire": begin
                        code = $fscanf(fd, "%h %d %h", pc_val, rd_val, value);
                        if (code != 3) bad_record("retire");
                        else wait_retire(pc_val, rd_val, value);
                    end
                    "memchk": begin
                        code = $fscanf(fd, "%h %h", addr, value);
                        if (code != 2) begin
                            bad_record("memchk");
                        end else begin
                            host_access(1'b0, addr, '0, rdata);
                            check_word($sformatf("mem[%h]", addr), value, rdata);
                        end
                    end
                    "halt":  wait_stop(1'b1);
                    "error": wait_stop(1'b0);
                    "reset": begin
                        apply_reset();
                        check_flag("halted after reset", 1'b0, halted);
                        check_flag("error after reset", 1'b0, error);
                        check_word("pc after reset", RESET_PC, retire_pc);
                    end
                    default: bad_record("unknown");
                endcase
            end
            $fclose(fd);
        end

        finish_test();
        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/core_patterns.txt
# Records: load <word addr> <word>, retire <pc> <rd> <data>, memchk <word addr> <word>
# Also: test <name>, run, halt, error, reset; retire data is not compared when rd is 0
test arith
load 000 00500093  load 001 ffd00113
load 002 002081b3  load 003 40208233
load 004 00309293  load 005 40115313
load 006 01c15393  load 007 00112433
load 008 001134b3  load 009 0020c533
load 00a 0020e5b3  load 00b 0020f633
load 00c 00708013  load 00d 000006b3
load 00e 00108463  load 010 00109463
load 011 008007ef  load 013 05d00867
load 017 00114463  load 019 00116463
load 01a 10a02023  load 01b 10002883
load 01c 00100073
run
retire 00000000 1 00000005  retire 00000004 2 fffffffd
retire 00000008 3 00000002  retire 0000000c 4 00000008
retire 00000010 5 00000028  retire 00000014 6 fffffffe
retire 00000018 7 0000000f  retire 0000001c 8 00000001
retire 00000020 9 00000000  retire 00000024 10 fffffff8
retire 00000028 11 fffffffd  retire 0000002c 12 00000005
retire 00000030 0 00000000  retire 00000034 13 00000000
test control
retire 00000038 0 00000000  retire 00000040 0 00000000
retire 00000044 15 00000048  retire 0000004c 16 00000050
retire 0000005c 0 00000000  retire 00000064 0 00000000
test memory
retire 00000068 0 00000000  retire 0000006c 17 fffffff8
test halt
retire 00000070 0 00000000
halt
test readback
memchk 040 fffffff8
test illegal
reset
load 000 00900093  load 001 0000007f
run
retire 00000000 1 00000009  retire 00000004 0 00000000
error

// File: flist.f
verilog/rv_pkg.sv
verilog/mem_pkg.sv
verilog/regfile.sv
verilog/unified_mem.sv
verilog/mem_arbiter.sv
verilog/fetch_unit.sv
verilog/decoder.sv
verilog/execute_unit.sv
verilog/load_store_unit.sv
verilog/core_top.sv
testbench/tb_core_top.sv
